// ==== source/xm_pkg.sv ====
`default_nettype none

package xm_pkg;

    typedef logic [15:0] word_t;    // register and memory data word
    typedef logic [15:0] addr_t;    // VRAM or XR address
    typedef logic [7:0]  byte_t;    // host bus byte
    typedef logic [3:0]  intr_t;    // one bit per interrupt source

    // host register numbers, each 16 bits wide, accessed as two bytes
    typedef enum logic [3:0] {
        XM_SYS_CTRL  = 4'h0,        // busy, blanking, write mask
        XM_INT_CTRL  = 4'h1,        // interrupt mask and status
        XM_TIMER     = 4'h2,        // 1/10 ms timer
        XM_RD_XADDR  = 4'h3,
        XM_WR_XADDR  = 4'h4,
        XM_XDATA     = 4'h5,
        XM_RD_INCR   = 4'h6,
        XM_RD_ADDR   = 4'h7,
        XM_WR_INCR   = 4'h8,
        XM_WR_ADDR   = 4'h9,
        XM_DATA      = 4'hA,
        XM_DATA_2    = 4'hB,        // second alias of DATA
        XM_UNUSED_0C = 4'hC,
        XM_UNUSED_0D = 4'hD,
        XM_UNUSED_0E = 4'hE,
        XM_UNUSED_0F = 4'hF
    } xm_reg_e;

    localparam int TIMER_HZ = 10000;    // tenth of a millisecond tick

endpackage

`default_nettype wire

// ==== source/xm_bus_sync.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_bus_sync (
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire logic            bus_cs_n_i,        // async chip select, active low
    input  wire logic            bus_rd_nwr_i,      // 1 = read, 0 = write
    input  wire logic [3:0]      bus_reg_num_i,
    input  wire logic            bus_bytesel_i,     // 0 = even byte, 1 = odd byte
    input  wire xm_pkg::byte_t   bus_data_i,
    output logic                 write_strobe_o,
    output logic                 read_strobe_o,
    output xm_pkg::xm_reg_e      reg_num_o,
    output logic                 bytesel_o,
    output xm_pkg::byte_t        data_byte_o
);
    import xm_pkg::*;

    logic [1:0] cs_n_sync;          // [1] is the synchronized level
    logic       cs_n_last;          // previous synchronized select
    logic [1:0] rd_nwr_sync;
    logic [1:0] bytesel_sync;
    logic [3:0] reg_num_s1;
    logic [3:0] reg_num_s2;
    byte_t      data_s1;
    byte_t      data_s2;
    logic       cs_fall;

    assign cs_fall = cs_n_last & ~cs_n_sync[1];     // high to low on select

    // select path, reset so no strobe fires out of reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync      <= 2'b11;
            cs_n_last      <= 1'b1;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            cs_n_sync      <= {cs_n_sync[0], bus_cs_n_i};
            cs_n_last      <= cs_n_sync[1];
            write_strobe_o <= cs_fall & ~rd_nwr_sync[1];
            read_strobe_o  <= cs_fall & rd_nwr_sync[1];
        end
    end

    // address, direction and data stages
    always_ff @(posedge clk) begin
        rd_nwr_sync  <= {rd_nwr_sync[0], bus_rd_nwr_i};
        bytesel_sync <= {bytesel_sync[0], bus_bytesel_i};
        reg_num_s1   <= bus_reg_num_i;
        reg_num_s2   <= reg_num_s1;
        data_s1      <= bus_data_i;
        data_s2      <= data_s1;
        if (cs_fall) begin
            reg_num_o   <= xm_reg_e'(reg_num_s2);   // held until next access
            bytesel_o   <= bytesel_sync[1];
            data_byte_o <= data_s2;
        end
    end

endmodule

`default_nettype wire

// ==== source/xm_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_timer #(
    parameter int PCLK_HZ = 25_000_000      // clock rate in hertz
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    output xm_pkg::word_t    count_o        // tenths of a millisecond
);
    import xm_pkg::*;

    localparam int TICKS   = PCLK_HZ / TIMER_HZ;   // clocks per count step
    localparam int PRE_W   = $clog2(TICKS + 1);

    logic [PRE_W-1:0] prescale;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prescale <= '0;
            count_o  <= '0;
        end else begin
            if (prescale == PRE_W'(TICKS - 1)) begin
                prescale <= '0;
                count_o  <= count_o + 1'b1;     // wraps at 16'hFFFF
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/xm_read_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_read_mux (
    input  wire xm_pkg::xm_reg_e  reg_num_i,
    input  wire logic             bytesel_i,        // 0 selects the high half
    input  wire logic             mem_busy_i,
    input  wire logic             h_blank_i,
    input  wire logic             v_blank_i,
    input  wire logic [3:0]       wrmask_i,
    input  wire xm_pkg::intr_t    intr_mask_i,
    input  wire xm_pkg::intr_t    intr_status_i,
    input  wire xm_pkg::byte_t    timer_hi_i,       // live upper timer byte
    input  wire xm_pkg::byte_t    timer_lo_latch_i,
    input  wire xm_pkg::addr_t    rd_xaddr_i,
    input  wire xm_pkg::addr_t    wr_xaddr_i,
    input  wire xm_pkg::word_t    xdata_i,
    input  wire xm_pkg::word_t    rd_incr_i,
    input  wire xm_pkg::addr_t    rd_addr_i,
    input  wire xm_pkg::word_t    wr_incr_i,
    input  wire xm_pkg::addr_t    wr_addr_i,
    input  wire xm_pkg::word_t    data_i,
    output xm_pkg::byte_t         bus_data_o
);
    import xm_pkg::*;

    word_t read_word;

    always_comb begin
        case (reg_num_i)
            XM_SYS_CTRL:  read_word = {mem_busy_i, 3'b000, h_blank_i, v_blank_i, 6'b0, wrmask_i};
            XM_INT_CTRL:  read_word = {4'b0, intr_mask_i, 4'b0, intr_status_i};
            XM_TIMER:     read_word = {timer_hi_i, timer_lo_latch_i};
            XM_RD_XADDR:  read_word = rd_xaddr_i;
            XM_WR_XADDR:  read_word = wr_xaddr_i;
            XM_XDATA:     read_word = xdata_i;
            XM_RD_INCR:   read_word = rd_incr_i;
            XM_RD_ADDR:   read_word = rd_addr_i;
            XM_WR_INCR:   read_word = wr_incr_i;
            XM_WR_ADDR:   read_word = wr_addr_i;
            XM_DATA, XM_DATA_2,
            XM_UNUSED_0C, XM_UNUSED_0D,
            XM_UNUSED_0E, XM_UNUSED_0F:
                          read_word = data_i;       // unused slots mirror DATA
            default:      read_word = data_i;
        endcase
    end

    assign bus_data_o = bytesel_i ? read_word[7:0] : read_word[15:8];

endmodule

`default_nettype wire

// ==== source/xm_reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_reg_file (
    input  wire logic             clk,
    input  wire logic             reset_i,
    // decoded host access
    input  wire logic             write_strobe_i,
    input  wire logic             read_strobe_i,
    input  wire xm_pkg::xm_reg_e  reg_num_i,
    input  wire logic             bytesel_i,
    input  wire xm_pkg::byte_t    data_byte_i,
    input  wire xm_pkg::word_t    timer_count_i,
    // memory side
    input  wire logic             vram_ack_i,       // one cycle, data valid with it
    input  wire logic             xr_ack_i,
    input  wire xm_pkg::word_t    regs_data_i,
    input  wire xm_pkg::word_t    xr_data_i,
    output logic                  regs_vram_sel_o,
    output logic                  regs_xr_sel_o,
    output logic                  regs_wr_o,
    output logic [3:0]            regs_wrmask_o,    // VRAM nibble write mask
    output xm_pkg::addr_t         regs_addr_o,
    output xm_pkg::word_t         regs_data_o,
    // control and status
    output xm_pkg::intr_t         intr_mask_o,
    output xm_pkg::intr_t         intr_clear_o,     // one cycle pulse
    output logic                  mem_busy_o,
    output xm_pkg::byte_t         timer_lo_latch_o,
    // host visible registers
    output xm_pkg::addr_t         rd_xaddr_o,
    output xm_pkg::addr_t         wr_xaddr_o,
    output xm_pkg::word_t         xdata_o,
    output xm_pkg::word_t         rd_incr_o,
    output xm_pkg::addr_t         rd_addr_o,
    output xm_pkg::word_t         wr_incr_o,
    output xm_pkg::addr_t         wr_addr_o,
    output xm_pkg::word_t         data_o
);
    import xm_pkg::*;

    logic   xr_rd;              // XR pre-read outstanding
    logic   vram_rd;            // VRAM pre-read outstanding
    byte_t  xdata_even;         // high byte waiting for XDATA low byte
    byte_t  data_even;          // high byte waiting for DATA low byte

    logic   wr_even;
    logic   wr_odd;
    logic   rd_odd;
    logic   is_data;            // DATA or its alias
    logic   start_xr_rd;
    logic   start_xr_wr;
    logic   start_vram_rd;
    logic   start_vram_wr;

    // even byte is the high half
    function automatic word_t set_byte(input word_t w, input logic odd, input byte_t b);
        word_t r;
        r = w;
        if (odd) begin
            r[7:0] = b;
        end else begin
            r[15:8] = b;
        end
        return r;
    endfunction

    assign wr_even = write_strobe_i & ~bytesel_i;
    assign wr_odd  = write_strobe_i & bytesel_i;
    assign rd_odd  = read_strobe_i & bytesel_i;
    assign is_data = (reg_num_i == XM_DATA) || (reg_num_i == XM_DATA_2);

    // odd byte kicks off the memory cycle
    assign start_xr_rd   = (wr_odd && reg_num_i == XM_RD_XADDR) ||
                           (rd_odd && reg_num_i == XM_XDATA);
    assign start_xr_wr   = wr_odd && reg_num_i == XM_XDATA;
    assign start_vram_rd = (wr_odd && reg_num_i == XM_RD_ADDR) || (rd_odd && is_data);
    assign start_vram_wr = wr_odd && is_data;

    assign mem_busy_o = regs_vram_sel_o | regs_xr_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_vram_sel_o  <= 1'b0;
            regs_xr_sel_o    <= 1'b0;
            regs_wr_o        <= 1'b0;
            xr_rd            <= 1'b0;
            vram_rd          <= 1'b0;
            regs_wrmask_o    <= 4'b1111;
            intr_mask_o      <= '0;
            intr_clear_o     <= '0;
            timer_lo_latch_o <= '0;
            rd_xaddr_o       <= '0;
            wr_xaddr_o       <= '0;
            xdata_o          <= '0;
            rd_incr_o        <= '0;
            rd_addr_o        <= '0;
            wr_incr_o        <= '0;
            wr_addr_o        <= '0;
            data_o           <= '0;
        end else begin
            intr_clear_o <= '0;

            if (vram_ack_i) begin
                if (vram_rd) begin
                    data_o    <= regs_data_i;
                    rd_addr_o <= rd_addr_o + rd_incr_o;
                end
                if (regs_wr_o) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;
                end
                regs_vram_sel_o <= 1'b0;
                regs_wr_o       <= 1'b0;
                vram_rd         <= 1'b0;
            end

            if (xr_ack_i) begin
                if (xr_rd) begin
                    xdata_o    <= xr_data_i;
                    rd_xaddr_o <= rd_xaddr_o + 1'b1;
                end
                if (regs_wr_o) begin
                    wr_xaddr_o <= wr_xaddr_o + 1'b1;
                end
                regs_xr_sel_o <= 1'b0;
                regs_wr_o     <= 1'b0;
                xr_rd         <= 1'b0;
            end

            // host writes win over an ack increment in the same cycle
            if (write_strobe_i) begin
                case (reg_num_i)
                    XM_SYS_CTRL: begin
                        if (bytesel_i) begin
                            regs_wrmask_o <= data_byte_i[3:0];
                        end
                    end
                    XM_INT_CTRL: begin
                        if (bytesel_i) begin
                            intr_clear_o <= data_byte_i[3:0];
                        end else begin
                            intr_mask_o  <= data_byte_i[3:0];
                        end
                    end
                    XM_RD_XADDR: rd_xaddr_o <= set_byte(rd_xaddr_o, bytesel_i, data_byte_i);
                    XM_WR_XADDR: wr_xaddr_o <= set_byte(wr_xaddr_o, bytesel_i, data_byte_i);
                    XM_RD_INCR:  rd_incr_o  <= set_byte(rd_incr_o, bytesel_i, data_byte_i);
                    XM_RD_ADDR:  rd_addr_o  <= set_byte(rd_addr_o, bytesel_i, data_byte_i);
                    XM_WR_INCR:  wr_incr_o  <= set_byte(wr_incr_o, bytesel_i, data_byte_i);
                    XM_WR_ADDR:  wr_addr_o  <= set_byte(wr_addr_o, bytesel_i, data_byte_i);
                    default: begin
                    end
                endcase
            end

            if (start_xr_rd) begin
                regs_xr_sel_o <= 1'b1;
                regs_wr_o     <= 1'b0;
                xr_rd         <= 1'b1;
            end
            if (start_xr_wr) begin
                regs_xr_sel_o <= 1'b1;
                regs_wr_o     <= 1'b1;
                xr_rd         <= 1'b0;
            end
            if (start_vram_rd) begin
                regs_vram_sel_o <= 1'b1;
                regs_wr_o       <= 1'b0;
                vram_rd         <= 1'b1;
            end
            if (start_vram_wr) begin
                regs_vram_sel_o <= 1'b1;
                regs_wr_o       <= 1'b1;
                vram_rd         <= 1'b0;
            end

            // keeps TIMER halves consistent across a carry
            if (read_strobe_i && !bytesel_i) begin
                timer_lo_latch_o <= timer_count_i[7:0];
            end
        end
    end

    // memory address and data, plus the held high bytes
    always_ff @(posedge clk) begin
        if (wr_even && reg_num_i == XM_XDATA) begin
            xdata_even <= data_byte_i;
        end
        if (wr_even && is_data) begin
            data_even <= data_byte_i;
        end
        if (wr_odd && reg_num_i == XM_RD_XADDR) begin
            regs_addr_o <= {rd_xaddr_o[15:8], data_byte_i};    // new address, not the stored one
        end else if (wr_odd && reg_num_i == XM_RD_ADDR) begin
            regs_addr_o <= {rd_addr_o[15:8], data_byte_i};
        end else if (start_xr_wr) begin
            regs_addr_o <= wr_xaddr_o;
            regs_data_o <= {xdata_even, data_byte_i};
        end else if (start_vram_wr) begin
            regs_addr_o <= wr_addr_o;
            regs_data_o <= {data_even, data_byte_i};
        end else if (start_xr_rd) begin
            regs_addr_o <= rd_xaddr_o;      // next XDATA pre-read
        end else if (start_vram_rd) begin
            regs_addr_o <= rd_addr_o;       // next DATA pre-read
        end
    end

endmodule

`default_nettype wire

// ==== source/xm_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_regs #(
    parameter int PCLK_HZ = 25_000_000
) (
    input  wire logic            clk,
    input  wire logic            reset_i,
    // host bus
    input  wire logic            bus_cs_n_i,
    input  wire logic            bus_rd_nwr_i,
    input  wire logic [3:0]      bus_reg_num_i,
    input  wire logic            bus_bytesel_i,
    input  wire xm_pkg::byte_t   bus_data_i,
    output xm_pkg::byte_t        bus_data_o,
    // VRAM and XR
    input  wire logic            vram_ack_i,
    input  wire logic            xr_ack_i,
    output logic                 regs_vram_sel_o,
    output logic                 regs_xr_sel_o,
    output logic                 regs_wr_o,
    output logic [3:0]           regs_wrmask_o,
    output xm_pkg::addr_t        regs_addr_o,
    output xm_pkg::word_t        regs_data_o,
    input  wire xm_pkg::word_t   regs_data_i,
    input  wire xm_pkg::word_t   xr_data_i,
    // video status and interrupts
    input  wire logic            h_blank_i,
    input  wire logic            v_blank_i,
    input  wire xm_pkg::intr_t   intr_status_i,
    output xm_pkg::intr_t        intr_mask_o,
    output xm_pkg::intr_t        intr_clear_o
);
    import xm_pkg::*;

    logic    write_strobe;
    logic    read_strobe;
    xm_reg_e reg_num;
    logic    bytesel;
    byte_t   data_byte;
    word_t   timer_count;
    logic    mem_busy;
    byte_t   timer_lo_latch;
    addr_t   rd_xaddr;
    addr_t   wr_xaddr;
    word_t   xdata;
    word_t   rd_incr;
    addr_t   rd_addr;
    word_t   wr_incr;
    addr_t   wr_addr;
    word_t   data;

    xm_bus_sync i_bus_sync (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),
        .write_strobe_o(write_strobe), .read_strobe_o(read_strobe),
        .reg_num_o(reg_num), .bytesel_o(bytesel), .data_byte_o(data_byte)
    );

    xm_timer #(.PCLK_HZ(PCLK_HZ)) i_timer (
        .clk(clk), .reset_i(reset_i), .count_o(timer_count)
    );

    xm_reg_file i_reg_file (
        .clk(clk), .reset_i(reset_i),
        .write_strobe_i(write_strobe), .read_strobe_i(read_strobe),
        .reg_num_i(reg_num), .bytesel_i(bytesel), .data_byte_i(data_byte),
        .timer_count_i(timer_count),
        .vram_ack_i(vram_ack_i), .xr_ack_i(xr_ack_i),
        .regs_data_i(regs_data_i), .xr_data_i(xr_data_i),
        .regs_vram_sel_o(regs_vram_sel_o), .regs_xr_sel_o(regs_xr_sel_o),
        .regs_wr_o(regs_wr_o), .regs_wrmask_o(regs_wrmask_o),
        .regs_addr_o(regs_addr_o), .regs_data_o(regs_data_o),
        .intr_mask_o(intr_mask_o), .intr_clear_o(intr_clear_o),
        .mem_busy_o(mem_busy), .timer_lo_latch_o(timer_lo_latch),
        .rd_xaddr_o(rd_xaddr), .wr_xaddr_o(wr_xaddr), .xdata_o(xdata),
        .rd_incr_o(rd_incr), .rd_addr_o(rd_addr),
        .wr_incr_o(wr_incr), .wr_addr_o(wr_addr), .data_o(data)
    );

    xm_read_mux i_read_mux (
        .reg_num_i(reg_num), .bytesel_i(bytesel),
        .mem_busy_i(mem_busy), .h_blank_i(h_blank_i), .v_blank_i(v_blank_i),
        .wrmask_i(regs_wrmask_o), .intr_mask_i(intr_mask_o),
        .intr_status_i(intr_status_i),
        .timer_hi_i(timer_count[15:8]),     // high byte read live
        .timer_lo_latch_i(timer_lo_latch),
        .rd_xaddr_i(rd_xaddr), .wr_xaddr_i(wr_xaddr), .xdata_i(xdata),
        .rd_incr_i(rd_incr), .rd_addr_i(rd_addr),
        .wr_incr_i(wr_incr), .wr_addr_i(wr_addr), .data_i(data),
        .bus_data_o(bus_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/xm_regs_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module xm_regs_tb;
    import xm_pkg::*;

    localparam int NUM = 81;            // table entries
    localparam logic [1:0] OP_W = 2'd0; // write byte
    localparam logic [1:0] OP_R = 2'd1; // read byte
    localparam logic [1:0] OP_I = 2'd2; // wait until both selects are low
    localparam logic [1:0] OP_S = 2'd3; // status: hblank, vblank, slow memory, intr status

    typedef struct packed {
        logic [1:0] op;
        logic [3:0] reg_num;
        logic       bsel;
        logic [7:0] val;
        logic [7:0] exp;
        logic       chk;
    } entry_t;

    logic clk;
    logic reset_i;
    logic bus_cs_n_i;
    logic bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic bus_bytesel_i;
    byte_t bus_data_i;
    byte_t bus_data_o;
    logic vram_ack_i;
    logic xr_ack_i;
    logic regs_vram_sel_o;
    logic regs_xr_sel_o;
    logic regs_wr_o;
    logic [3:0] regs_wrmask_o;
    addr_t regs_addr_o;
    word_t regs_data_o;
    word_t regs_data_i;
    word_t xr_data_i;
    logic h_blank_i;
    logic v_blank_i;
    intr_t intr_status_i;
    intr_t intr_mask_o;
    intr_t intr_clear_o;

    word_t vram [256];
    logic [3:0] vram_mask [256];        // mask seen with each VRAM write
    word_t xr [256];
    int vram_wait;
    int xr_wait;
    logic slow_mem;                     // holds the ack off across the next bus access
    logic [31:0] lfsr = 32'h798c;
    int edges;                          // clocks since reset release
    int sample_edge;                    // clock count when a read byte was sampled
    intr_t clear_seen;
    int checks;
    int errors;
    logic [7:0] t_hi;
    int t_edge;
    int t_prev_val;
    int t_prev_edge;
    int t_pairs;

    entry_t stim [NUM] = '{
    // register readback, even byte is the high half
    '{OP_W, XM_RD_INCR, 1'b0, 8'h12, 8'h00, 1'b0}, '{OP_W, XM_RD_INCR, 1'b1, 8'h34, 8'h00, 1'b0},
    '{OP_W, XM_WR_INCR, 1'b0, 8'h56, 8'h00, 1'b0}, '{OP_W, XM_WR_INCR, 1'b1, 8'h78, 8'h00, 1'b0},
    '{OP_W, XM_WR_ADDR, 1'b0, 8'h9A, 8'h00, 1'b0}, '{OP_W, XM_WR_ADDR, 1'b1, 8'hBC, 8'h00, 1'b0},
    '{OP_W, XM_WR_XADDR, 1'b0, 8'hDE, 8'h00, 1'b0}, '{OP_W, XM_WR_XADDR, 1'b1, 8'hF0, 8'h00, 1'b0},
    '{OP_R, XM_RD_INCR, 1'b0, 8'h00, 8'h12, 1'b1}, '{OP_R, XM_RD_INCR, 1'b1, 8'h00, 8'h34, 1'b1},
    '{OP_R, XM_WR_INCR, 1'b0, 8'h00, 8'h56, 1'b1}, '{OP_R, XM_WR_INCR, 1'b1, 8'h00, 8'h78, 1'b1},
    '{OP_R, XM_WR_ADDR, 1'b0, 8'h00, 8'h9A, 1'b1}, '{OP_R, XM_WR_ADDR, 1'b1, 8'h00, 8'hBC, 1'b1},
    '{OP_R, XM_WR_XADDR, 1'b0, 8'h00, 8'hDE, 1'b1}, '{OP_R, XM_WR_XADDR, 1'b1, 8'h00, 8'hF0, 1'b1},
    // VRAM writes, increment 3 from 0x0010, mask 0x5
    '{OP_W, XM_WR_INCR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_WR_INCR, 1'b1, 8'h03, 8'h00, 1'b0},
    '{OP_W, XM_WR_ADDR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_WR_ADDR, 1'b1, 8'h10, 8'h00, 1'b0},
    '{OP_W, XM_SYS_CTRL, 1'b1, 8'h05, 8'h00, 1'b0}, '{OP_W, XM_DATA, 1'b0, 8'h11, 8'h00, 1'b0},
    '{OP_W, XM_DATA, 1'b1, 8'h22, 8'h00, 1'b0}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_W, XM_DATA, 1'b0, 8'h33, 8'h00, 1'b0}, '{OP_W, XM_DATA, 1'b1, 8'h44, 8'h00, 1'b0},
    '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_DATA, 1'b0, 8'h55, 8'h00, 1'b0},
    '{OP_W, XM_DATA, 1'b1, 8'h66, 8'h00, 1'b0}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_R, XM_WR_ADDR, 1'b0, 8'h00, 8'h00, 1'b1}, '{OP_R, XM_WR_ADDR, 1'b1, 8'h00, 8'h19, 1'b1},
    // VRAM pre-read from 0x0020
    '{OP_W, XM_RD_INCR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_RD_INCR, 1'b1, 8'h01, 8'h00, 1'b0},
    '{OP_W, XM_RD_ADDR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_RD_ADDR, 1'b1, 8'h20, 8'h00, 1'b0},
    '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_R, XM_DATA, 1'b0, 8'h00, 8'h7A, 1'b1},
    '{OP_R, XM_DATA, 1'b1, 8'h00, 8'h20, 1'b1}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_R, XM_DATA, 1'b0, 8'h00, 8'h7B, 1'b1}, '{OP_R, XM_UNUSED_0C, 1'b1, 8'h00, 8'h21, 1'b1},
    '{OP_R, XM_RD_ADDR, 1'b0, 8'h00, 8'h00, 1'b1}, '{OP_R, XM_RD_ADDR, 1'b1, 8'h00, 8'h22, 1'b1},
    // XR writes from 0x0040, pre-read at 0x0080
    '{OP_W, XM_WR_XADDR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_WR_XADDR, 1'b1, 8'h40, 8'h00, 1'b0},
    '{OP_W, XM_XDATA, 1'b0, 8'hAB, 8'h00, 1'b0}, '{OP_W, XM_XDATA, 1'b1, 8'hCD, 8'h00, 1'b0},
    '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_XDATA, 1'b0, 8'h12, 8'h00, 1'b0},
    '{OP_W, XM_XDATA, 1'b1, 8'h34, 8'h00, 1'b0}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_R, XM_WR_XADDR, 1'b0, 8'h00, 8'h00, 1'b1}, '{OP_R, XM_WR_XADDR, 1'b1, 8'h00, 8'h42, 1'b1},
    '{OP_W, XM_RD_XADDR, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_W, XM_RD_XADDR, 1'b1, 8'h80, 8'h00, 1'b0},
    '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_R, XM_XDATA, 1'b0, 8'h00, 8'h7F, 1'b1},
    '{OP_R, XM_XDATA, 1'b1, 8'h00, 8'h80, 1'b1}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    // status bits, interrupt mask and clear, busy bit
    '{OP_S, XM_SYS_CTRL, 1'b0, 8'hC5, 8'h00, 1'b0}, '{OP_R, XM_SYS_CTRL, 1'b0, 8'h00, 8'h0C, 1'b1},
    '{OP_R, XM_SYS_CTRL, 1'b1, 8'h00, 8'h05, 1'b1}, '{OP_W, XM_INT_CTRL, 1'b0, 8'h0A, 8'h00, 1'b0},
    '{OP_R, XM_INT_CTRL, 1'b0, 8'h00, 8'h0A, 1'b1}, '{OP_R, XM_INT_CTRL, 1'b1, 8'h00, 8'h05, 1'b1},
    '{OP_W, XM_INT_CTRL, 1'b1, 8'h06, 8'h06, 1'b1}, '{OP_S, XM_SYS_CTRL, 1'b0, 8'h10, 8'h00, 1'b0},
    '{OP_W, XM_DATA, 1'b0, 8'h77, 8'h00, 1'b0}, '{OP_W, XM_DATA, 1'b1, 8'h88, 8'h00, 1'b0},
    '{OP_R, XM_SYS_CTRL, 1'b0, 8'h00, 8'h80, 1'b1}, '{OP_I, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_R, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b1}, '{OP_S, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    // timer pairs, checked by check_timer
    '{OP_R, XM_TIMER, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_R, XM_TIMER, 1'b1, 8'h00, 8'h00, 1'b0},
    '{OP_S, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_S, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_S, XM_SYS_CTRL, 1'b0, 8'h00, 8'h00, 1'b0}, '{OP_R, XM_TIMER, 1'b0, 8'h00, 8'h00, 1'b0},
    '{OP_R, XM_TIMER, 1'b1, 8'h00, 8'h00, 1'b0}
    };

    xm_regs #(.PCLK_HZ(100000)) i_xm_regs (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset_i) begin
            edges++;
        end
    end

    always @(negedge clk) begin
        if (intr_clear_o != '0) begin
            clear_seen = intr_clear_o;      // any nonzero pulse in the entry
        end
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = next_lfsr(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    // VRAM and XR models, ack 1 to 4 clocks after the select
    always @(negedge clk) begin
        vram_ack_i = 1'b0;
        xr_ack_i = 1'b0;
        if (reset_i) begin
            vram_wait = 0;
            xr_wait = 0;
        end else begin
            if (vram_wait > 0) begin
                vram_wait--;
                if (vram_wait == 0) begin
                    vram_ack_i = 1'b1;
                    if (regs_wr_o) begin
                        vram[regs_addr_o[7:0]] = regs_data_o;
                        vram_mask[regs_addr_o[7:0]] = regs_wrmask_o;
                    end else begin
                        regs_data_i = vram[regs_addr_o[7:0]];
                    end
                end
            end else if (regs_vram_sel_o) begin
                vram_wait = slow_mem ? 20 : 1 + take_bits(2);
            end
            if (xr_wait > 0) begin
                xr_wait--;
                if (xr_wait == 0) begin
                    xr_ack_i = 1'b1;
                    if (regs_wr_o) begin
                        xr[regs_addr_o[7:0]] = regs_data_o;
                    end else begin
                        xr_data_i = xr[regs_addr_o[7:0]];
                    end
                end
            end else if (regs_xr_sel_o) begin
                xr_wait = slow_mem ? 20 : 1 + take_bits(2);
            end
        end
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_range(input string what, input int got, input int lo, input int hi);
        checks++;
        assert (got >= lo && got <= hi) else begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    // one bus access, chip select low for 6 clocks then high for 4
    task automatic bus_cycle(input logic rd, input logic [3:0] rn, input logic bs,
                             input logic [7:0] wd, output logic [7:0] rd_byte);
        bus_rd_nwr_i = rd;
        bus_reg_num_i = rn;
        bus_bytesel_i = bs;
        bus_data_i = wd;
        bus_cs_n_i = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            @(negedge clk);
            if (i == 5) begin
                rd_byte = bus_data_o;
                sample_edge = edges;
            end
        end
        bus_cs_n_i = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_idle();
        while (regs_vram_sel_o || regs_xr_sel_o) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // even byte read latches the low byte, so a pair must form one count value
    task automatic check_timer(input logic odd, input logic [7:0] b);
        int val;
        int span;
        if (!odd) begin
            t_hi = b;
            t_edge = sample_edge;
        end else begin
            val = int'({t_hi, b});
            check_range("TIMER word", val, (t_edge - 2) / 10, t_edge / 10);
            if (t_pairs > 0) begin
                span = t_edge - t_prev_edge;
                check_range("TIMER step", val - t_prev_val, span / 10, (span + 9) / 10);
            end
            t_prev_val = val;
            t_prev_edge = t_edge;
            t_pairs++;
        end
    endtask

    initial begin
        #((NUM * 20 + 2000) * 4);
        $display("Timeout: the run did not finish in time, %0d errors so far", errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        entry_t e;
        logic [7:0] rd_byte;
        reset_i = 1'b1;
        bus_cs_n_i = 1'b1;
        bus_rd_nwr_i = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i = 8'h00;
        vram_ack_i = 1'b0;
        xr_ack_i = 1'b0;
        regs_data_i = '0;
        xr_data_i = '0;
        h_blank_i = 1'b0;
        v_blank_i = 1'b0;
        intr_status_i = '0;
        slow_mem = 1'b0;
        for (int a = 0; a < 256; a++) begin
            vram[a] = {8'(a) ^ 8'h5A, 8'(a)};
            xr[a] = {~8'(a), 8'(a)};
            vram_mask[a] = 4'h0;
        end
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        for (int n = 0; n < NUM; n++) begin
            e = stim[n];
            clear_seen = '0;
            case (e.op)
                OP_W: begin
                    bus_cycle(1'b0, e.reg_num, e.bsel, e.val, rd_byte);
                    if (e.chk) begin
                        check_value($sformatf("entry %0d intr clear", n),
                                    16'(clear_seen), 16'(e.exp));
                    end
                end
                OP_R: begin
                    bus_cycle(1'b1, e.reg_num, e.bsel, 8'h00, rd_byte);
                    if (e.chk) begin
                        check_value($sformatf("entry %0d reg %0d", n, e.reg_num),
                                    16'(rd_byte), 16'(e.exp));
                    end
                    if (e.reg_num == XM_TIMER) begin
                        check_timer(e.bsel, rd_byte);
                    end
                end
                OP_I: wait_idle();
                default: begin
                    h_blank_i = e.val[7];
                    v_blank_i = e.val[6];
                    slow_mem = e.val[4];
                    intr_status_i = e.val[3:0];
                    repeat (10) @(negedge clk);
                end
            endcase
        end
        check_value("VRAM 0x10", vram[8'h10], 16'h1122);
        check_value("VRAM 0x13", vram[8'h13], 16'h3344);
        check_value("VRAM 0x16", vram[8'h16], 16'h5566);
        check_value("mask 0x10", 16'(vram_mask[8'h10]), 16'h0005);
        check_value("mask 0x13", 16'(vram_mask[8'h13]), 16'h0005);
        check_value("mask 0x16", 16'(vram_mask[8'h16]), 16'h0005);
        check_value("XR 0x40", xr[8'h40], 16'hABCD);
        check_value("XR 0x41", xr[8'h41], 16'h1234);
        check_value("intr mask output", 16'(intr_mask_o), 16'h000A);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/xm_pkg.sv
source/xm_bus_sync.sv
source/xm_timer.sv
source/xm_read_mux.sv
source/xm_reg_file.sv
source/xm_regs.sv
sim/xm_regs_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module xm_regs_tb -f all.f -o xm_regs_sim \
    && ./obj_dir/xm_regs_sim | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
